// ==== nfu_activation.sv ====
/* NFU-3 activation
   Coefficient RAM and piecewise-linear sigmoid over Q8.8 values, with bypass */

`timescale 1ns/100ps

module nfu_activation #(
    parameter int Tn = 4
) (
    input  logic                                           clk,
    input  logic                                           i_rst,
    input  nfu_pkg::pipe_tag_t                             i_tag,
    input  logic [Tn-1:0][nfu_pkg::SUM_WIDTH-1:0]          i_sums,
    input  logic                                           i_coef_we,
    input  logic [nfu_pkg::SEG_BITS-1:0]                   i_coef_addr,
    input  nfu_pkg::coef_t                                 i_coef,
    output nfu_pkg::pipe_tag_t                             o_tag,
    output logic [Tn-1:0][nfu_pkg::BIT_WIDTH-1:0]          o_values,
    output logic [Tn-1:0][nfu_pkg::SUM_WIDTH-1:0]          o_sums
);

    localparam int NSEG = 2 ** nfu_pkg::SEG_BITS;

    // One slope/offset pair per segment
    nfu_pkg::coef_t                         coef_mem [NSEG];
    logic [Tn-1:0][nfu_pkg::BIT_WIDTH-1:0]  act_vals;

    // Write port runs apart from the data stream
    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int k = 0; k < NSEG; k++) begin
                coef_mem[k] <= '0;
            end
        end else if (i_coef_we) begin
            coef_mem[i_coef_addr] <= i_coef;
        end
    end

    for (genvar r = 0; r < Tn; r++) begin : g_lane
        logic signed [nfu_pkg::SUM_WIDTH-1:0]  sum_s;
        logic signed [nfu_pkg::BIT_WIDTH-1:0]  x;
        logic [nfu_pkg::SEG_BITS-1:0]          seg;
        nfu_pkg::coef_t                        c;
        logic signed [nfu_pkg::SUM_WIDTH-1:0]  ax;
        logic signed [nfu_pkg::SUM_WIDTH-1:0]  b_ext;
        logic signed [nfu_pkg::BIT_WIDTH-1:0]  y;

        always_comb begin
            sum_s = i_sums[r];
            // Drop the fraction of the product scale, clamp to Q8.8
            x     = nfu_pkg::sat16(sum_s >>> nfu_pkg::FRAC_BITS);
            // Sign and bit 14 split the range into quarters
            seg   = {~x[nfu_pkg::BIT_WIDTH-1], x[nfu_pkg::BIT_WIDTH-2]};
            c     = coef_mem[seg];
            ax    = c.a * x;
            b_ext = c.b;
            y     = nfu_pkg::sat16(b_ext + (ax >>> nfu_pkg::FRAC_BITS));
            act_vals[r] = i_tag.cmd.activate ? y : x;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_tag <= '0;
        end else begin
            o_tag <= i_tag;
        end
    end

    // Raw sums follow for the partial-sum output
    always_ff @(posedge clk) begin
        o_values <= act_vals;
        o_sums   <= i_sums;
    end

endmodule

// ==== nfu_adder_tree.sv ====
/* NFU-2 adder tree
   Sums each row of products with a partial sum and keeps the last sums for accumulation */

`timescale 1ns/100ps

module nfu_adder_tree #(
    parameter int Tn = 4
) (
    input  logic                                           clk,
    input  logic                                           i_rst,
    input  nfu_pkg::pipe_tag_t                             i_tag,
    input  logic [Tn*Tn-1:0][nfu_pkg::SUM_WIDTH-1:0]       i_products,
    input  logic [Tn-1:0][nfu_pkg::SUM_WIDTH-1:0]          i_psum,
    output nfu_pkg::pipe_tag_t                             o_tag,
    output logic [Tn-1:0][nfu_pkg::SUM_WIDTH-1:0]          o_sums
);

    // Sums of the most recent valid item
    logic [Tn-1:0][nfu_pkg::SUM_WIDTH-1:0] held_sums;
    logic [Tn-1:0][nfu_pkg::SUM_WIDTH-1:0] psum_sel;
    logic [Tn-1:0][nfu_pkg::SUM_WIDTH-1:0] next_sums;

    // Partial-sum source mux
    always_comb begin
        for (int r = 0; r < Tn; r++) begin
            case (i_tag.cmd.op)
                nfu_pkg::OP_ACCUM: psum_sel[r] = held_sums[r];
                nfu_pkg::OP_LOAD:  psum_sel[r] = i_psum[r];
                default:           psum_sel[r] = '0;
            endcase
        end
    end

    for (genvar r = 0; r < Tn; r++) begin : g_row
        // Heap-ordered tree with leaves at Tn..2Tn-1 and the root at 1
        logic [2*Tn-1:1][nfu_pkg::SUM_WIDTH-1:0] node;

        always_comb begin
            for (int j = 0; j < Tn; j++) begin
                node[Tn+j] = i_products[r*Tn+j];
            end
            for (int k = Tn - 1; k >= 1; k--) begin
                node[k] = node[2*k] + node[2*k+1];
            end
        end

        // Wraps at SUM_WIDTH
        assign next_sums[r] = node[1] + psum_sel[r];
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_tag     <= '0;
            held_sums <= '0;
        end else begin
            o_tag <= i_tag;
            // Bubbles leave the held sums untouched
            if (i_tag.valid) begin
                held_sums <= next_sums;
            end
        end
    end

    always_ff @(posedge clk) begin
        o_sums <= next_sums;
    end

endmodule

// ==== nfu_multiplier.sv ====
/* NFU-1 multiplier array
   Registered Tn x Tn signed products of neurons and synapses */

`timescale 1ns/100ps

module nfu_multiplier #(
    parameter int Tn = 4
) (
    input  logic                                           clk,
    input  logic                                           i_rst,
    input  nfu_pkg::pipe_tag_t                             i_tag,
    input  logic [Tn-1:0][nfu_pkg::BIT_WIDTH-1:0]          i_neurons,
    input  logic [Tn*Tn-1:0][nfu_pkg::BIT_WIDTH-1:0]       i_synapses,
    input  logic [Tn-1:0][nfu_pkg::SUM_WIDTH-1:0]          i_psum,
    output nfu_pkg::pipe_tag_t                             o_tag,
    output logic [Tn*Tn-1:0][nfu_pkg::SUM_WIDTH-1:0]       o_products,
    output logic [Tn-1:0][nfu_pkg::SUM_WIDTH-1:0]          o_psum
);

    // Row r, column j uses neuron j, product index r*Tn+j
    for (genvar r = 0; r < Tn; r++) begin : g_row
        for (genvar j = 0; j < Tn; j++) begin : g_col
            always_ff @(posedge clk) begin
                o_products[r*Tn+j] <= $signed(i_neurons[j]) * $signed(i_synapses[r*Tn+j]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_tag <= '0;
        end else begin
            o_tag <= i_tag;
        end
    end

    // Partial sum waits one cycle beside the products
    always_ff @(posedge clk) begin
        o_psum <= i_psum;
    end

endmodule

// ==== nfu_pipeline_properties.sv ====
/* NFU pipeline timing checks
   Output valid timing and coefficient write rules bound to the top level */

`timescale 1ns/100ps

module nfu_pipeline_properties (
    input logic clk,
    input logic i_rst,
    input logic i_valid,
    input logic i_coef_we,
    input logic o_valid
);

    // Register stages from i_valid to o_valid
    localparam int LATENCY = 5;

    // Number of assertion failures so far
    int fail_count = 0;

    // Reset flushes every tag
    a_valid_low_in_reset: assert property (@(posedge clk) i_rst |=> !o_valid)
        else begin
            $error("o_valid high after a reset cycle");
            fail_count++;
        end

    // Nothing in flight right after reset
    a_valid_low_after_reset: assert property (@(posedge clk) $fell(i_rst) |-> !o_valid [*LATENCY])
        else begin
            $error("o_valid high too soon after reset");
            fail_count++;
        end

    a_valid_delay: assert property (@(posedge clk) disable iff (i_rst)
        o_valid == $past(i_valid, LATENCY))
        else begin
            $error("o_valid is not i_valid delayed by the pipeline latency");
            fail_count++;
        end

    a_no_coef_write_in_reset: assert property (@(posedge clk) i_rst |-> !i_coef_we)
        else begin
            $error("coefficient write during reset");
            fail_count++;
        end

endmodule

bind nfu_pipeline_top nfu_pipeline_properties u_props (
    .clk       (clk),
    .i_rst     (i_rst),
    .i_valid   (i_valid),
    .i_coef_we (i_coef_we),
    .o_valid   (o_valid)
);

// ==== nfu_pipeline_tb.sv ====
/* NFU pipeline testbench
   LFSR stimulus, reference model and in-order checking of every output item */

`timescale 1ns/100ps

module nfu_pipeline_tb;

    localparam int TN = 4;
    localparam int WAIT_LIMIT = 100;

    typedef logic [TN-1:0][nfu_pkg::BIT_WIDTH-1:0]    lanes_t;
    typedef logic [TN*TN-1:0][nfu_pkg::BIT_WIDTH-1:0] syn_t;
    typedef logic [TN-1:0][nfu_pkg::SUM_WIDTH-1:0]    sums_t;

    // Expected outputs of one item
    typedef struct packed {
        lanes_t data;
        sums_t  psum;
    } result_t;

    logic                         clk;
    logic                         i_rst;
    logic                         i_valid;
    nfu_pkg::nfu_cmd_t            i_cmd;
    lanes_t                       i_neurons;
    syn_t                         i_synapses;
    sums_t                        i_psum;
    logic                         i_coef_we;
    logic [nfu_pkg::SEG_BITS-1:0] i_coef_addr;
    nfu_pkg::coef_t               i_coef;
    logic                         o_valid;
    lanes_t                       o_data;
    sums_t                        o_psum;

    // Model copies of the coefficient RAM and the held sums
    nfu_pkg::coef_t model_coef [4];
    sums_t          model_last;
    result_t        exp_q [$];
    logic [31:0]    lfsr;
    int             out_count;
    string          test_name;
    lanes_t         stim_n;
    syn_t           stim_s;
    sums_t          stim_p;

    // Sums at the segment edges where 32'h8000_0000 and 32'h7fff_ffff saturate x
    int edge_vals [12] = '{32'h8000_0000, -16385 * 256, -16384 * 256, -256,
                           0, 16383 * 256, 16384 * 256, 32767 * 256,
                           32'h7fff_ffff, -16384 * 256 - 1, 255, 16384 * 256 - 1};

    nfu_pipeline_top #(.Tn(TN)) UUT (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // Fibonacci LFSR with taps 32 22 2 1 and one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic int clamp(input int v, input int lo, input int hi);
        if (v > hi) return hi;
        if (v < lo) return lo;
        return v;
    endfunction

    function automatic nfu_pkg::nfu_cmd_t make_cmd(input nfu_pkg::nfu_op_e op, input int in_prec,
                                                   input int out_prec, input logic act);
        nfu_pkg::nfu_cmd_t c;
        c.op       = op;
        c.in_prec  = 4'(in_prec);
        c.out_prec = 4'(out_prec);
        c.activate = act;
        c.spare    = 1'b0;
        return c;
    endfunction

    // Reference model of one item through unpack, NFU-1..3 and pack
    function automatic result_t nfu_ref(input nfu_pkg::nfu_cmd_t cmd, input lanes_t neurons,
                                        input syn_t syn, input sums_t psum, input sums_t last);
        result_t     res;
        logic [15:0] w;
        int          nval [TN];
        int          acc;
        int          x;
        int          y;
        int          seg;
        int          lim;
        // Copy bit in_prec into every bit above it
        for (int j = 0; j < TN; j++) begin
            w = neurons[j];
            for (int b = 0; b < nfu_pkg::BIT_WIDTH; b++) begin
                if (b > cmd.in_prec) w[b] = w[cmd.in_prec];
            end
            nval[j] = int'($signed(w));
        end
        for (int r = 0; r < TN; r++) begin
            case (cmd.op)
                nfu_pkg::OP_ACCUM: acc = last[r];
                nfu_pkg::OP_LOAD:  acc = psum[r];
                default:           acc = 0;
            endcase
            // int arithmetic wraps at 32 bits
            for (int j = 0; j < TN; j++) begin
                acc += nval[j] * int'($signed(syn[r*TN+j]));
            end
            res.psum[r] = acc;
            x = clamp(acc >>> nfu_pkg::FRAC_BITS, -32768, 32767);
            y = x;
            if (cmd.activate) begin
                if (x < -16384) seg = 0;
                else if (x < 0) seg = 1;
                else if (x < 16384) seg = 2;
                else seg = 3;
                y = int'($signed(model_coef[seg].b))
                    + ((int'($signed(model_coef[seg].a)) * x) >>> nfu_pkg::FRAC_BITS);
                y = clamp(y, -32768, 32767);
            end
            lim = 1 << cmd.out_prec;
            res.data[r] = 16'(clamp(y, -lim, lim - 1));
        end
        return res;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "run stopped");
    endtask

    task automatic compare_value(input string name, input logic [127:0] expected,
                                 input logic [127:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
            $display("tests failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // Inputs change half a nanosecond after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #0.5;
    endtask

    task automatic idle(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic random_payload();
        for (int j = 0; j < TN; j++) begin
            stim_n[j] = 16'(take_bits(16));
            stim_p[j] = take_bits(32);
        end
        for (int k = 0; k < TN * TN; k++) begin
            stim_s[k] = 16'(take_bits(16));
        end
    endtask

    task automatic send_item(input nfu_pkg::nfu_cmd_t cmd);
        result_t res;
        res        = nfu_ref(cmd, stim_n, stim_s, stim_p, model_last);
        // Every valid item replaces the held sums
        model_last = res.psum;
        exp_q.push_back(res);
        i_valid    = 1'b1;
        i_cmd      = cmd;
        i_neurons  = stim_n;
        i_synapses = stim_s;
        i_psum     = stim_p;
        next_cycle();
        i_valid    = 1'b0;
    endtask

    task automatic write_coef(input int addr, input logic [15:0] a, input logic [15:0] b);
        i_coef_we   = 1'b1;
        i_coef_addr = 2'(addr);
        i_coef      = {a, b};
        model_coef[addr] = {a, b};
        next_cycle();
        i_coef_we   = 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            if (n == WAIT_LIMIT) fail_run("timeout waiting for the pipeline to drain");
            next_cycle();
            n++;
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        result_t exp;
        if (!i_rst && o_valid) begin
            if (exp_q.size() == 0) begin
                fail_run("o_valid high with no item in flight");
            end else begin
                exp = exp_q.pop_front();
                compare_value($sformatf("%s o_data", test_name), exp.data, o_data);
                compare_value($sformatf("%s o_psum", test_name), exp.psum, o_psum);
                out_count++;
            end
        end
    end

    // Failures of the bound timing assertions
    always @(negedge clk) begin
        if (UUT.u_props.fail_count != 0) begin
            fail_run("a bound timing assertion failed");
        end
    end

    initial begin
        nfu_pkg::nfu_op_e  seq_ops [8];
        int                seq_gaps [8];
        nfu_pkg::nfu_cmd_t cmd;
        nfu_pkg::nfu_op_e  op;
        int                lat;
        int                base;
        int                outp;
        logic              act;
        lfsr        = 32'he498_4aa1;
        i_rst       = 1'b1;
        i_valid     = 1'b0;
        i_cmd       = '0;
        i_neurons   = '0;
        i_synapses  = '0;
        i_psum      = '0;
        i_coef_we   = 1'b0;
        i_coef_addr = '0;
        i_coef      = '0;
        out_count   = 0;
        model_last  = '0;
        for (int k = 0; k < 4; k++) model_coef[k] = '0;

        test_name = "reset";
        repeat (10) begin
            next_cycle();
            compare_value(test_name, 0, o_valid);
        end
        i_rst = 1'b0;
        repeat (3) begin
            next_cycle();
            compare_value(test_name, 0, o_valid);
        end

        // Edge at which o_valid is first seen counted from the accepting edge
        test_name = "latency";
        random_payload();
        send_item(make_cmd(nfu_pkg::OP_FIRST, 15, 15, 1'b0));
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
            if (lat > WAIT_LIMIT) fail_run("timeout waiting for o_valid");
        end while (!o_valid);
        next_cycle();
        compare_value(test_name, 5, lat);
        idle(8);

        test_name = "precision";
        for (int ip = 0; ip < 16; ip++) begin
            random_payload();
            outp = int'(take_bits(4));
            send_item(make_cmd(nfu_pkg::OP_FIRST, ip, outp, 1'b0));
        end
        wait_drain();

        // Partial-sum sources with gaps between items
        test_name = "psum";
        seq_ops  = '{nfu_pkg::OP_LOAD, nfu_pkg::OP_ACCUM, nfu_pkg::OP_ACCUM, nfu_pkg::OP_ACCUM,
                     nfu_pkg::OP_FIRST, nfu_pkg::OP_ACCUM, nfu_pkg::OP_LOAD, nfu_pkg::OP_ACCUM};
        seq_gaps = '{3, 0, 7, 0, 2, 0, 0, 1};
        for (int k = 0; k < 8; k++) begin
            random_payload();
            send_item(make_cmd(seq_ops[k], 7, 15, 1'b0));
            idle(seq_gaps[k]);
        end
        wait_drain();

        // Slopes large enough to saturate at both ends
        test_name = "activation";
        write_coef(0, 16'hfc00, 16'h0000);
        write_coef(1, 16'h0080, 16'h0100);
        write_coef(2, 16'h00c0, 16'h0080);
        write_coef(3, 16'hfe00, 16'h4000);
        for (int k = 0; k < 6; k++) begin
            random_payload();
            stim_n = '0;
            for (int r = 0; r < TN; r++) stim_p[r] = edge_vals[(k % 3) * TN + r];
            send_item(make_cmd(nfu_pkg::OP_LOAD, 15, (k < 3) ? 15 : 7, 1'b1));
        end
        wait_drain();

        test_name = "throughput";
        base = out_count;
        for (int k = 0; k < 200; k++) begin
            op   = nfu_pkg::nfu_op_e'(take_bits(2) % 3);
            lat  = int'(take_bits(4));
            outp = int'(take_bits(4));
            act  = 1'(take_bits(1));
            random_payload();
            cmd  = make_cmd(op, lat, outp, act);
            send_item(cmd);
        end
        // The last item leaves five cycles after it is accepted
        idle(5);
        compare_value("throughput count", 200, out_count - base);

        idle(4);
        if (exp_q.size() != 0) begin
            fail_run("items left in the expected queue");
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

// ==== nfu_pipeline_top.sv ====
/* NFU pipeline top level
   Unpack, multiply, reduce, activate and pack, five cycles from input to output */

`timescale 1ns/100ps

module nfu_pipeline_top #(
    parameter int Tn = 4
) (
    input  logic                                           clk,
    input  logic                                           i_rst,
    // Item stream, no back-pressure
    input  logic                                           i_valid,
    input  nfu_pkg::nfu_cmd_t                              i_cmd,
    input  logic [Tn-1:0][nfu_pkg::BIT_WIDTH-1:0]          i_neurons,
    input  logic [Tn*Tn-1:0][nfu_pkg::BIT_WIDTH-1:0]       i_synapses,
    input  logic [Tn-1:0][nfu_pkg::SUM_WIDTH-1:0]          i_psum,
    // Sigmoid coefficient write port
    input  logic                                           i_coef_we,
    input  logic [nfu_pkg::SEG_BITS-1:0]                   i_coef_addr,
    input  nfu_pkg::coef_t                                 i_coef,
    // Results
    output logic                                           o_valid,
    output logic [Tn-1:0][nfu_pkg::BIT_WIDTH-1:0]          o_data,
    output logic [Tn-1:0][nfu_pkg::SUM_WIDTH-1:0]          o_psum
);

    // Tags between stages
    nfu_pkg::pipe_tag_t in_tag;
    nfu_pkg::pipe_tag_t unpk_tag;
    nfu_pkg::pipe_tag_t mul_tag;
    nfu_pkg::pipe_tag_t add_tag;
    nfu_pkg::pipe_tag_t act_tag;

    // Unpacker to NFU-1
    logic [Tn-1:0][nfu_pkg::BIT_WIDTH-1:0]     unpk_neurons;
    logic [Tn*Tn-1:0][nfu_pkg::BIT_WIDTH-1:0]  unpk_synapses;
    logic [Tn-1:0][nfu_pkg::SUM_WIDTH-1:0]     unpk_psum;

    // NFU-1 to NFU-2
    logic [Tn*Tn-1:0][nfu_pkg::SUM_WIDTH-1:0]  mul_products;
    logic [Tn-1:0][nfu_pkg::SUM_WIDTH-1:0]     mul_psum;

    // NFU-2 to NFU-3 and NFU-3 to packer
    logic [Tn-1:0][nfu_pkg::SUM_WIDTH-1:0]     add_sums;
    logic [Tn-1:0][nfu_pkg::BIT_WIDTH-1:0]     act_values;
    logic [Tn-1:0][nfu_pkg::SUM_WIDTH-1:0]     act_sums;

    assign in_tag = '{valid: i_valid, cmd: i_cmd};

    precision_unpacker #(.Tn(Tn)) u_unpacker (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_tag      (in_tag),
        .i_neurons  (i_neurons),
        .i_synapses (i_synapses),
        .i_psum     (i_psum),
        .o_tag      (unpk_tag),
        .o_neurons  (unpk_neurons),
        .o_synapses (unpk_synapses),
        .o_psum     (unpk_psum)
    );

    nfu_multiplier #(.Tn(Tn)) u_nfu1 (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_tag      (unpk_tag),
        .i_neurons  (unpk_neurons),
        .i_synapses (unpk_synapses),
        .i_psum     (unpk_psum),
        .o_tag      (mul_tag),
        .o_products (mul_products),
        .o_psum     (mul_psum)
    );

    nfu_adder_tree #(.Tn(Tn)) u_nfu2 (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_tag      (mul_tag),
        .i_products (mul_products),
        .i_psum     (mul_psum),
        .o_tag      (add_tag),
        .o_sums     (add_sums)
    );

    nfu_activation #(.Tn(Tn)) u_nfu3 (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_tag       (add_tag),
        .i_sums      (add_sums),
        .i_coef_we   (i_coef_we),
        .i_coef_addr (i_coef_addr),
        .i_coef      (i_coef),
        .o_tag       (act_tag),
        .o_values    (act_values),
        .o_sums      (act_sums)
    );

    precision_packer #(.Tn(Tn)) u_packer (
        .clk      (clk),
        .i_rst    (i_rst),
        .i_tag    (act_tag),
        .i_values (act_values),
        .i_sums   (act_sums),
        .o_valid  (o_valid),
        .o_data   (o_data),
        .o_psum   (o_psum)
    );

endmodule

// ==== nfu_pkg.sv ====
/* NFU pipeline shared definitions
   Widths, command and tag structs, partial-sum opcodes and saturation helpers */

package nfu_pkg;

    // Word widths
    parameter int BIT_WIDTH = 16;
    parameter int SUM_WIDTH = 32;
    parameter int FRAC_BITS = 8;

    // Precision fields hold (bits - 1)
    parameter int PREC_W = 4;

    // Sigmoid segment address, 4 segments
    parameter int SEG_BITS = 2;

    // Saturation limits of a full-width word
    parameter int SAT_MAX = 2 ** (BIT_WIDTH - 1) - 1;
    parameter int SAT_MIN = -(2 ** (BIT_WIDTH - 1));

    // Partial-sum source for the adder tree
    typedef enum logic [1:0] {
        OP_FIRST = 2'd0,
        OP_ACCUM = 2'd1,
        OP_LOAD  = 2'd2
    } nfu_op_e;

    typedef struct packed {
        nfu_op_e             op;
        logic [PREC_W-1:0]   in_prec;
        logic [PREC_W-1:0]   out_prec;
        logic                activate;
        logic                spare;
    } nfu_cmd_t;

    // One linear segment, Q8.8 slope and offset
    typedef struct packed {
        logic signed [BIT_WIDTH-1:0] a;
        logic signed [BIT_WIDTH-1:0] b;
    } coef_t;

    // Control that travels beside the data
    typedef struct packed {
        logic     valid;
        nfu_cmd_t cmd;
    } pipe_tag_t;

    // Clamp a wide signed value to a full-width word
    function automatic logic signed [BIT_WIDTH-1:0] sat16(input logic signed [SUM_WIDTH-1:0] v);
        if (v > SAT_MAX) return BIT_WIDTH'(SAT_MAX);
        if (v < SAT_MIN) return BIT_WIDTH'(SAT_MIN);
        return BIT_WIDTH'(v);
    endfunction

    // Clamp to prec+1 signed bits, result stays sign-extended
    function automatic logic signed [BIT_WIDTH-1:0] sat_prec(
        input logic signed [BIT_WIDTH-1:0] v,
        input logic [PREC_W-1:0]           prec
    );
        int hi;
        int lo;
        hi = (1 << prec) - 1;
        lo = -(1 << prec);
        if (v > hi) return BIT_WIDTH'(hi);
        if (v < lo) return BIT_WIDTH'(lo);
        return v;
    endfunction

endpackage

// ==== precision_packer.sv ====
/* Output packer
   Saturates each result to the output precision, keeps it sign-extended */

`timescale 1ns/100ps

module precision_packer #(
    parameter int Tn = 4
) (
    input  logic                                           clk,
    input  logic                                           i_rst,
    input  nfu_pkg::pipe_tag_t                             i_tag,
    input  logic [Tn-1:0][nfu_pkg::BIT_WIDTH-1:0]          i_values,
    input  logic [Tn-1:0][nfu_pkg::SUM_WIDTH-1:0]          i_sums,
    output logic                                           o_valid,
    output logic [Tn-1:0][nfu_pkg::BIT_WIDTH-1:0]          o_data,
    output logic [Tn-1:0][nfu_pkg::SUM_WIDTH-1:0]          o_psum
);

    logic [Tn-1:0][nfu_pkg::BIT_WIDTH-1:0] sat_vals;

    // Clamp to out_prec+1 signed bits per lane
    always_comb begin
        for (int r = 0; r < Tn; r++) begin
            sat_vals[r] = nfu_pkg::sat_prec($signed(i_values[r]), i_tag.cmd.out_prec);
        end
    end

    // Last stage, only the valid bit of the tag leaves
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_tag.valid;
        end
    end

    always_ff @(posedge clk) begin
        o_data <= sat_vals;
        o_psum <= i_sums;
    end

endmodule

// ==== precision_unpacker.sv ====
/* Neuron unpacker
   Sign-extends each packed lane from the input precision to full width */

`timescale 1ns/100ps

module precision_unpacker #(
    parameter int Tn = 4
) (
    input  logic                                           clk,
    input  logic                                           i_rst,
    input  nfu_pkg::pipe_tag_t                             i_tag,
    input  logic [Tn-1:0][nfu_pkg::BIT_WIDTH-1:0]          i_neurons,
    input  logic [Tn*Tn-1:0][nfu_pkg::BIT_WIDTH-1:0]       i_synapses,
    input  logic [Tn-1:0][nfu_pkg::SUM_WIDTH-1:0]          i_psum,
    output nfu_pkg::pipe_tag_t                             o_tag,
    output logic [Tn-1:0][nfu_pkg::BIT_WIDTH-1:0]          o_neurons,
    output logic [Tn*Tn-1:0][nfu_pkg::BIT_WIDTH-1:0]       o_synapses,
    output logic [Tn-1:0][nfu_pkg::SUM_WIDTH-1:0]          o_psum
);

    // Shift that moves the sign bit of the packed value to the MSB
    logic [nfu_pkg::PREC_W-1:0]                 ext_shift;
    logic [Tn-1:0][nfu_pkg::BIT_WIDTH-1:0]      ext_neurons;

    assign ext_shift = nfu_pkg::PREC_W'(nfu_pkg::BIT_WIDTH - 1) - i_tag.cmd.in_prec;

    // Shift up then arithmetic shift down, bits above in_prec are dropped
    always_comb begin
        logic [nfu_pkg::BIT_WIDTH-1:0] shifted;
        for (int l = 0; l < Tn; l++) begin
            shifted = i_neurons[l] << ext_shift;
            ext_neurons[l] = $signed(shifted) >>> ext_shift;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_tag <= '0;
        end else begin
            o_tag <= i_tag;
        end
    end

    // Synapses and partial sums ride in the same register as their neurons
    always_ff @(posedge clk) begin
        o_neurons  <= ext_neurons;
        o_synapses <= i_synapses;
        o_psum     <= i_psum;
    end

endmodule

// ==== src.f ====
nfu_pkg.sv
precision_unpacker.sv
nfu_multiplier.sv
nfu_adder_tree.sv
nfu_activation.sv
precision_packer.sv
nfu_pipeline_top.sv
nfu_pipeline_properties.sv
nfu_pipeline_tb.sv
